// ==== Makefile ====
TOP = out_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== list.f ====
source/out_pkg.sv
source/col_stream_if.sv
source/axis_out_shift.sv
source/packet_arbiter.sv
source/out_stage_top.sv
tests/out_stage_asserts.sv
tests/out_stage_tb.sv

// ==== source/axis_out_shift.sv ====
`timescale 1ns/1ps

module axis_out_shift import out_pkg::*; (
  input  logic                                     aclk,
  input  logic                                     aresetn,
  input  logic                                     s_valid,
  input  logic                                     s_last,
  output logic                                     s_ready,
  input  tuser_st                                  s_user,
  input  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data,
  col_stream_if.source                             m
);

  // ******************************
  // column masks per kernel width
  // ******************************

  logic [KW_MAX/2:0][COLS-1:0] lut_valid;
  logic [KW_MAX/2:0][COLS-1:0] lut_valid_tail;
  logic [KW_MAX/2:0][COLS-1:0] lut_last;
  logic [KW_MAX/2:0][COLS-1:0] lut_tail_end;

  // entry h is kernel width 2h+1, bit i is column c = i+1
  for (genvar h = 0; h <= KW_MAX / 2; h++) begin : g_kw
    for (genvar i = 0; i < COLS; i++) begin : g_col
      assign lut_valid[h][i]      = ((i + 1) % (2 * h + 1) == 0);
      assign lut_valid_tail[h][i] = (((i + 1) % (2 * h + 1) > h) || lut_valid[h][i]) &&
                                    ((i + 1) <= (COLS / (2 * h + 1)) * (2 * h + 1));
      assign lut_last[h][i]       = ((i + 1) == 2 * h + 1);
      assign lut_tail_end[h][i]   = ((i + 1) == h + 1);
    end
  end

  logic            keep_block;
  logic [COLS-1:0] sel_valid;
  logic [COLS-1:0] sel_last;
  logic [COLS-1:0] sel_last_pkt;

  assign keep_block   = !s_user.is_config && !s_user.is_w_first_kw2;
  assign sel_valid    = s_user.is_w_last ? lut_valid_tail[s_user.kw2] : lut_valid[s_user.kw2];
  assign sel_last     = s_user.is_w_last ? lut_tail_end[s_user.kw2] : lut_last[s_user.kw2];
  assign sel_last_pkt = s_last ? lut_tail_end[s_user.kw2] : '0;

  // ******************************
  // shift control
  // ******************************

  shift_state_e                               state;
  logic [CNT_BITS-1:0]                        cnt;
  logic [COLS-1:0]                            shift_valid;
  logic [COLS-1:0]                            shift_last;
  logic [COLS-1:0]                            shift_last_pkt;
  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0]  shift_data;
  tuser_st                                    user_q;
  logic                                       load;
  logic                                       step;

  // masked blocks see s_ready high in IDLE and simply vanish
  assign load = (state == IDLE) && s_valid && keep_block;
  assign step = (state == SHIFT) && m.ready;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state          <= IDLE;
      s_ready        <= 1'b1;
      cnt            <= CNT_BITS'(COLS);
      shift_valid    <= '0;
      shift_last     <= '0;
      shift_last_pkt <= '0;
    end else if (load) begin
      state          <= SHIFT;
      s_ready        <= 1'b0;
      shift_valid    <= sel_valid;
      shift_last     <= sel_last;
      shift_last_pkt <= sel_last_pkt;
    end else if (step) begin
      shift_valid    <= shift_valid << 1;
      shift_last     <= shift_last << 1;
      shift_last_pkt <= shift_last_pkt << 1;
      if (cnt == CNT_BITS'(1)) begin
        state   <= IDLE;
        s_ready <= 1'b1;
        cnt     <= CNT_BITS'(COLS);
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      shift_data <= s_data;
      user_q     <= s_user;
    end else if (step) begin
      shift_data <= shift_data << (ROWS * WORD_WIDTH);
    end
  end

  // top column leaves first
  assign m.valid    = shift_valid[COLS-1];
  assign m.last     = shift_last[COLS-1];
  assign m.last_pkt = shift_last_pkt[COLS-1];
  assign m.data     = shift_data[COLS-1];
  assign m.user     = user_q;

endmodule

// ==== source/col_stream_if.sv ====
`timescale 1ns/1ps

// one column per beat, shifter to arbiter
interface col_stream_if import out_pkg::*; ();

  logic                                valid;
  logic                                ready;
  logic                                last;
  logic                                last_pkt;
  tuser_st                             user;
  logic [ROWS-1:0][WORD_WIDTH-1:0]     data;

  modport source (
    output valid,
    output last,
    output last_pkt,
    output user,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  last_pkt,
    input  user,
    input  data,
    output ready
  );

endinterface

// ==== source/out_pkg.sv ====
package out_pkg;

  // ******************************
  // block geometry
  // ******************************

  // words per column
  localparam int ROWS       = 4;
  // columns per result block
  localparam int COLS       = 8;
  // largest odd kernel width
  localparam int KW_MAX     = 7;
  localparam int WORD_WIDTH = 16;

  // half kernel index runs 0 .. KW_MAX/2
  localparam int KW2_BITS = $clog2(KW_MAX / 2 + 1);

  // shifter column counter, counts COLS down to 1
  localparam int CNT_BITS = $clog2(COLS + 1);

  // ******************************
  // stream sideband
  // ******************************

  typedef struct packed {
    // kernel width is 2*kw2+1
    logic [KW2_BITS-1:0] kw2;
    // last block of a row, tail columns become valid
    logic is_w_last;
    // warm-up block, dropped at the shifter input
    logic is_w_first_kw2;
    // configuration block, also dropped
    logic is_config;
  } tuser_st;

  // ******************************
  // state and grant encodings
  // ******************************

  typedef enum logic {
    IDLE,
    SHIFT
  } shift_state_e;

  typedef enum logic {
    GRANT_A,
    GRANT_B
  } grant_e;

endpackage

// ==== source/out_stage_top.sv ====
`timescale 1ns/1ps

module out_stage_top import out_pkg::*; (
  input  logic                                     aclk,
  input  logic                                     aresetn,

  // core A
  input  logic                                     s_valid_a,
  input  logic                                     s_last_a,
  output logic                                     s_ready_a,
  input  tuser_st                                  s_user_a,
  input  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data_a,

  // core B
  input  logic                                     s_valid_b,
  input  logic                                     s_last_b,
  output logic                                     s_ready_b,
  input  tuser_st                                  s_user_b,
  input  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data_b,

  // merged output stream
  input  logic                                     m_ready,
  output logic                                     m_valid,
  output logic                                     m_last,
  output logic                                     m_last_pkt,
  output tuser_st                                  m_user,
  output logic [ROWS-1:0][WORD_WIDTH-1:0]          m_data,
  output grant_e                                   m_src
);

  // ******************************
  // column streams
  // ******************************

  col_stream_if col_a ();
  col_stream_if col_b ();

  // ******************************
  // per-core shifters
  // ******************************

  axis_out_shift shift_a (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid_a),
    .s_last  (s_last_a),
    .s_ready (s_ready_a),
    .s_user  (s_user_a),
    .s_data  (s_data_a),
    .m       (col_a)
  );

  axis_out_shift shift_b (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid_b),
    .s_last  (s_last_b),
    .s_ready (s_ready_b),
    .s_user  (s_user_b),
    .s_data  (s_data_b),
    .m       (col_b)
  );

  // ******************************
  // packet merge
  // ******************************

  packet_arbiter arb (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .a          (col_a),
    .b          (col_b),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_last_pkt (m_last_pkt),
    .m_user     (m_user),
    .m_data     (m_data),
    .m_src      (m_src)
  );

endmodule

// ==== source/packet_arbiter.sv ====
`timescale 1ns/1ps

module packet_arbiter import out_pkg::*; (
  input  logic                            aclk,
  input  logic                            aresetn,
  col_stream_if.sink                      a,
  col_stream_if.sink                      b,
  input  logic                            m_ready,
  output logic                            m_valid,
  output logic                            m_last,
  output logic                            m_last_pkt,
  output tuser_st                         m_user,
  output logic [ROWS-1:0][WORD_WIDTH-1:0] m_data,
  output grant_e                          m_src
);

  grant_e grant;
  grant_e grant_next;
  grant_e peer;
  logic   pkt_open;
  logic   own_valid;
  logic   peer_valid;
  logic   beat;
  logic   pkt_end;

  assign peer       = (grant == GRANT_A) ? GRANT_B : GRANT_A;
  assign own_valid  = (grant == GRANT_A) ? a.valid : b.valid;
  assign peer_valid = (grant == GRANT_A) ? b.valid : a.valid;

  // ******************************
  // output steering
  // ******************************

  always_comb begin
    if (grant == GRANT_A) begin
      m_valid    = a.valid;
      m_last     = a.last;
      m_last_pkt = a.last_pkt;
      m_user     = a.user;
      m_data     = a.data;
    end else begin
      m_valid    = b.valid;
      m_last     = b.last;
      m_last_pkt = b.last_pkt;
      m_user     = b.user;
      m_data     = b.data;
    end
  end

  assign m_src = grant;

  // the owner follows m_ready, the other side may only step over
  // masked columns, those never reach the output
  assign a.ready = m_ready && ((grant == GRANT_A) || !a.valid);
  assign b.ready = m_ready && ((grant == GRANT_B) || !b.valid);

  // ******************************
  // packet lock
  // ******************************

  assign beat    = m_valid && m_ready;
  assign pkt_end = beat && m_last_pkt;

  always_comb begin
    grant_next = grant;
    // round robin at a packet end, or hand over an idle grant
    if (pkt_end || (!pkt_open && !own_valid && peer_valid)) begin
      grant_next = peer;
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      grant    <= GRANT_A;
      pkt_open <= 1'b0;
    end else begin
      grant <= grant_next;
      if (beat) begin
        pkt_open <= !m_last_pkt;
      end
    end
  end

endmodule

// ==== tests/out_stage_asserts.sv ====
`timescale 1ns/1ps

module out_stage_asserts import out_pkg::*; (
  input logic         aclk,
  input logic         aresetn,
  input logic         m_valid,
  input logic         m_ready,
  input logic         m_last_pkt,
  input logic         s_ready_a,
  input grant_e       m_src,
  input shift_state_e a_state
);

  // a held beat stays offered
  assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid)
    else $error("m_valid dropped before m_ready");

  // back-pressure freezes shift_a with s_ready_a low
  assert property (@(posedge aclk) disable iff (!aresetn)
    a_state == SHIFT && !m_ready |=> a_state == SHIFT && !s_ready_a)
    else $error("shift_a left SHIFT or raised s_ready_a under back-pressure");

  // grant locked inside a packet
  assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && m_ready && !m_last_pkt |=> m_src == $past(m_src))
    else $error("m_src changed inside a packet");

endmodule

bind out_stage_top out_stage_asserts chk (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .m_valid    (m_valid),
  .m_ready    (m_ready),
  .m_last_pkt (m_last_pkt),
  .s_ready_a  (s_ready_a),
  .m_src      (m_src),
  .a_state    (shift_a.state)
);

// ==== tests/out_stage_tb.sv ====
`timescale 1ns/1ps

module out_stage_tb import out_pkg::*; ();

  localparam int N_ROWS = 18;
  // rows below this index run from source A alone with m_ready held high
  localparam int N_SOLO = 10;

  typedef struct packed {
    grant_e              src;
    logic [KW2_BITS-1:0] kw2;
    logic                w_last;
    logic                last;
    logic                cfg;
    logic                w_first;
    logic [7:0]          salt;
  } row_t;

  typedef struct packed {
    logic [ROWS-1:0][WORD_WIDTH-1:0] data;
    tuser_st                         user;
    logic                            last;
    logic                            last_pkt;
    logic                            row_end;
    logic [7:0]                      row;
  } beat_t;

  logic                                      aclk;
  logic                                      aresetn;
  logic                                      s_valid_a;
  logic                                      s_last_a;
  logic                                      s_ready_a;
  tuser_st                                   s_user_a;
  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data_a;
  logic                                      s_valid_b;
  logic                                      s_last_b;
  logic                                      s_ready_b;
  tuser_st                                   s_user_b;
  logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] s_data_b;
  logic                                      m_ready;
  logic                                      m_valid;
  logic                                      m_last;
  logic                                      m_last_pkt;
  tuser_st                                   m_user;
  logic [ROWS-1:0][WORD_WIDTH-1:0]           m_data;
  grant_e                                    m_src;

  integer seed = 31;
  int     errors;
  int     beats;
  int     tests_done;
  logic   bp_on;
  row_t   table_rows [N_ROWS];
  beat_t  exp_a [$];
  beat_t  exp_b [$];
  beat_t  mon_exp;
  logic   pkt_ended;
  grant_e src_after_pkt;
  int     pkt_row;

  out_stage_top UUT (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // ******************************
  // stimulus table and reference
  // ******************************

  function automatic row_t make_row(input grant_e s, input int kw2, input bit wl,
                                    input bit l, input bit c, input bit wf,
                                    input logic [7:0] salt);
    row_t r;
    r.src     = s;
    r.kw2     = KW2_BITS'(kw2);
    r.w_last  = wl;
    r.last    = l;
    r.cfg     = c;
    r.w_first = wf;
    r.salt    = salt;
    return r;
  endfunction

  task automatic predict_block(input int idx, input row_t r,
                               input logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] blk);
    beat_t q [$];
    beat_t bt;
    int    k;
    int    c;
    int    kw2;
    int    limit;
    bit    keep;
    kw2   = int'(r.kw2);
    k     = 2 * kw2 + 1;
    limit = (COLS / k) * k;
    // top column leaves first, column number c is index plus one
    for (int i = COLS - 1; i >= 0; i--) begin
      c    = i + 1;
      keep = (c % k == 0) || (r.w_last && (c % k > kw2) && (c <= limit));
      if (keep) begin
        bt.data                = blk[i];
        bt.user.kw2            = r.kw2;
        bt.user.is_w_last      = r.w_last;
        bt.user.is_w_first_kw2 = r.w_first;
        bt.user.is_config      = r.cfg;
        bt.last                = r.w_last ? (c == kw2 + 1) : (c == k);
        bt.last_pkt            = r.last && (c == kw2 + 1);
        bt.row_end             = 1'b0;
        bt.row                 = 8'(idx);
        q.push_back(bt);
      end
    end
    q[q.size() - 1].row_end = 1'b1;
    foreach (q[j]) begin
      if (r.src == GRANT_A) exp_a.push_back(q[j]);
      else exp_b.push_back(q[j]);
    end
  endtask

  task automatic run_row(input int idx);
    row_t                                      r;
    tuser_st                                   u;
    logic [COLS-1:0][ROWS-1:0][WORD_WIDTH-1:0] blk;
    r = table_rows[idx];
    for (int c = 0; c < COLS; c++) begin
      for (int w = 0; w < ROWS; w++) begin
        blk[c][w] = WORD_WIDTH'($random(seed)) ^ {8'h00, r.salt};
      end
    end
    u.kw2            = r.kw2;
    u.is_w_last      = r.w_last;
    u.is_w_first_kw2 = r.w_first;
    u.is_config      = r.cfg;
    if (r.src == GRANT_A) begin
      s_valid_a = 1'b1;
      s_last_a  = r.last;
      s_user_a  = u;
      s_data_a  = blk;
    end else begin
      s_valid_b = 1'b1;
      s_last_b  = r.last;
      s_user_b  = u;
      s_data_b  = blk;
    end
    @(negedge aclk);
    while (!((r.src == GRANT_A) ? s_ready_a : s_ready_b)) @(negedge aclk);
    if (!r.cfg && !r.w_first) begin
      predict_block(idx, r, blk);
    end else begin
      tests_done++;
      $display("test %0d: dropped block consumed by source %s", idx, r.src.name());
    end
    @(posedge aclk);
    #1;
    if (r.src == GRANT_A) s_valid_a = 1'b0;
    else s_valid_b = 1'b0;
  endtask

  task automatic run_source(input grant_e s, input int first, input int last_idx);
    for (int idx = first; idx <= last_idx; idx++) begin
      if (table_rows[idx].src == s) run_row(idx);
    end
  endtask

  task automatic wait_drain();
    while (exp_a.size() != 0 || exp_b.size() != 0) @(negedge aclk);
    @(posedge aclk);
    #1;
  endtask

  // ******************************
  // compare tasks and monitor
  // ******************************

  task automatic check_data(input logic [ROWS-1:0][WORD_WIDTH-1:0] got, exp, input int row);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: test %0d data %h, expected %h", $time, row, got, exp);
    end
  endtask

  task automatic check_user(input tuser_st got, exp, input int row);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: test %0d user %h, expected %h", $time, row, got, exp);
    end
  endtask

  task automatic check_flags(input logic got_last, got_pkt, exp_last, exp_pkt, input int row);
    if (got_last !== exp_last || got_pkt !== exp_pkt) begin
      errors++;
      $display("MISMATCH at %0t: test %0d last/last_pkt %b%b, expected %b%b",
               $time, row, got_last, got_pkt, exp_last, exp_pkt);
    end
  endtask

  task automatic check_src(input grant_e got, exp, input int row);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: grant after packet end of test %0d is %s, expected %s",
               $time, row, got.name(), exp.name());
    end
  endtask

  always @(negedge aclk) begin
    // round robin hands the grant to the other source after each packet
    if (aresetn && pkt_ended) begin
      check_src(m_src, src_after_pkt, pkt_row);
      pkt_ended = 1'b0;
    end
    if (aresetn && m_valid && m_ready) begin
      beats++;
      if ((m_src == GRANT_A) ? (exp_a.size() == 0) : (exp_b.size() == 0)) begin
        errors++;
        $display("output beat from source %s at %0t with no block pending",
                 m_src.name(), $time);
      end else begin
        if (m_src == GRANT_A) mon_exp = exp_a.pop_front();
        else mon_exp = exp_b.pop_front();
        check_data(m_data, mon_exp.data, int'(mon_exp.row));
        check_user(m_user, mon_exp.user, int'(mon_exp.row));
        check_flags(m_last, m_last_pkt, mon_exp.last, mon_exp.last_pkt, int'(mon_exp.row));
        if (mon_exp.last_pkt) begin
          pkt_ended     = 1'b1;
          src_after_pkt = (m_src == GRANT_A) ? GRANT_B : GRANT_A;
          pkt_row       = int'(mon_exp.row);
        end
        if (mon_exp.row_end) begin
          tests_done++;
          $display("test %0d: drained from source %s, errors so far %0d",
                   mon_exp.row, m_src.name(), errors);
        end
      end
    end
  end

  // random back-pressure once both sources run
  always @(posedge aclk) begin
    #1;
    if (bp_on) m_ready = (($random(seed) & 3) != 0);
    else m_ready = 1'b1;
  end

  initial begin
    repeat (N_ROWS * COLS * 40) @(posedge aclk);
    $display("watchdog expired, blocks still pending: A %0d, B %0d beats",
             exp_a.size(), exp_b.size());
    $display("Finished with errors");
    $finish;
  end

  // ******************************
  // main sequence
  // ******************************

  initial begin
    aresetn   = 1'b0;
    bp_on     = 1'b0;
    m_ready   = 1'b1;
    s_valid_a = 1'b0;
    s_last_a  = 1'b0;
    s_user_a  = '0;
    s_data_a  = '0;
    s_valid_b = 1'b0;
    s_last_b  = 1'b0;
    s_user_b  = '0;
    s_data_b  = '0;
    errors    = 0;
    beats     = 0;
    tests_done = 0;
    pkt_ended = 1'b0;
    // src, kw2, w_last, last, config, warm-up, salt
    table_rows[0]  = make_row(GRANT_A, 0, 0, 0, 0, 0, 8'h11);
    table_rows[1]  = make_row(GRANT_A, 1, 0, 0, 0, 0, 8'h22);
    table_rows[2]  = make_row(GRANT_A, 2, 0, 0, 0, 0, 8'h33);
    table_rows[3]  = make_row(GRANT_A, 3, 0, 0, 0, 0, 8'h44);
    table_rows[4]  = make_row(GRANT_A, 1, 1, 1, 0, 0, 8'h55);
    table_rows[5]  = make_row(GRANT_A, 2, 1, 1, 0, 0, 8'h66);
    table_rows[6]  = make_row(GRANT_A, 3, 1, 1, 0, 0, 8'h77);
    table_rows[7]  = make_row(GRANT_A, 1, 0, 0, 1, 0, 8'h88);
    table_rows[8]  = make_row(GRANT_A, 2, 0, 0, 0, 1, 8'h99);
    table_rows[9]  = make_row(GRANT_A, 0, 1, 1, 0, 0, 8'haa);
    table_rows[10] = make_row(GRANT_A, 1, 0, 0, 0, 0, 8'hbb);
    table_rows[11] = make_row(GRANT_B, 2, 0, 0, 0, 0, 8'hcc);
    table_rows[12] = make_row(GRANT_A, 1, 1, 1, 0, 0, 8'hdd);
    table_rows[13] = make_row(GRANT_B, 2, 1, 1, 0, 0, 8'hee);
    table_rows[14] = make_row(GRANT_B, 3, 0, 0, 1, 0, 8'h12);
    table_rows[15] = make_row(GRANT_B, 0, 1, 1, 0, 0, 8'h23);
    table_rows[16] = make_row(GRANT_A, 3, 1, 1, 0, 0, 8'h34);
    table_rows[17] = make_row(GRANT_B, 1, 1, 1, 0, 0, 8'h45);
    repeat (10) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    @(posedge aclk);
    #1;
    run_source(GRANT_A, 0, N_SOLO - 1);
    wait_drain();
    bp_on = 1'b1;
    fork
      run_source(GRANT_A, N_SOLO, N_ROWS - 1);
      run_source(GRANT_B, N_SOLO, N_ROWS - 1);
    join
    wait_drain();
    repeat (20) @(posedge aclk);
    $display("%0d tests, %0d beats, %0d errors, pending A %0d B %0d",
             tests_done, beats, errors, exp_a.size(), exp_b.size());
    if (errors == 0 && exp_a.size() == 0 && exp_b.size() == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
